// File: Makefile
# Verilator build and run for the fetch vector unit
VERILATOR ?= verilator
TOP       ?= ifu_vec_tb
FLIST     ?= ifu_vec.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SOURCES := $(wildcard hdl/*.sv tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/gated_clk_cell.sv
/* Latch-based clock gate cell */
`default_nettype none

module gated_clk_cell (
  input  logic clk_in,
  input  logic local_en,
  input  logic module_en,
  input  logic scan_en,
  output logic clk_out
);

  logic clk_en;
  logic clk_en_lat;

  // Module enable keeps the clock running regardless of local need
  // Scan mode always lets the clock through
  assign clk_en = local_en | module_en | scan_en;

  // Enable latch, open during the low phase
  always_latch
  begin
    if (!clk_in)
      clk_en_lat <= clk_en;
  end

  // Glitch-free since the enable only moves while clk_in is low
  assign clk_out = clk_in & clk_en_lat;

endmodule

`default_nettype wire

// File: hdl/ifu_icache_inv.sv
/* Instruction-cache invalidate walker, one set per cycle */
`default_nettype none

module ifu_icache_inv (
  input  logic vec_sm_clk,
  input  logic cpurst_b,
  input  logic inv_req,
  output logic inv_done,
  output logic inv_busy
);

  import ifu_vec_pkg::*;

  localparam int               set_w    = $clog2(ICACHE_SETS);
  localparam logic [set_w-1:0] last_set = set_w'(ICACHE_SETS - 1);

  logic [set_w-1:0] set_cnt;
  logic             busy;
  logic             last;

  // Final set being cleared this cycle
  assign last = busy && (set_cnt == last_set);

  always_ff @(posedge vec_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      busy     <= 1'b0;
      set_cnt  <= '0;
      inv_done <= 1'b0;
    end
    else
    begin
      // Done pulse, one cycle after the last set
      inv_done <= last;
      if (!busy)
      begin
        // Requests only start an idle walker
        if (inv_req)
        begin
          busy    <= 1'b1;
          set_cnt <= '0;
        end
      end
      else if (last)
        busy <= 1'b0;
      else
        set_cnt <= set_cnt + 1'b1;
    end
  end

  assign inv_busy = busy;

endmodule

`default_nettype wire

// File: hdl/ifu_pcgen.sv
/* Fetch PC register, redirect load and sequential advance */
`default_nettype none

module ifu_pcgen (
  input  logic                             vec_sm_clk,
  input  logic                             cpurst_b,
  input  ifu_vec_pkg::vec_pcgen_t          pcgen,
  input  logic                             sm_on,
  input  logic                             fetch_en,
  output logic [ifu_vec_pkg::PC_WIDTH-1:0] fetch_pc
);

  import ifu_vec_pkg::*;

  // Clears the offset inside a fetch block
  localparam logic [PC_WIDTH-1:0] blk_mask = ~PC_WIDTH'(FETCH_BYTES - 1);

  logic                advance;
  logic [PC_WIDTH-1:0] redirect_pc;
  logic [PC_WIDTH-1:0] seq_pc;

  // No sequential fetch while the vector FSM owns the PC
  assign advance = fetch_en & ~sm_on & ~pcgen.reset_on;

  // Halfword to byte address
  assign redirect_pc = {pcgen.pc, 1'b0};

  // Next block, realigned after an odd redirect
  assign seq_pc = (fetch_pc + PC_WIDTH'(FETCH_BYTES)) & blk_mask;

  always_ff @(posedge vec_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      fetch_pc <= '0;
    else if (pcgen.pcload)
      fetch_pc <= redirect_pc;
    else if (advance)
      fetch_pc <= seq_pc;
  end

endmodule

`default_nettype wire

// File: hdl/ifu_vec_csr.sv
/* AXI4-Lite register block for the vector base, exception entry,
   vector-size configuration and FSM status */
`default_nettype none

module ifu_vec_csr (
  input  logic                    vec_sm_clk,
  input  logic                    cpurst_b,
  input  ifu_vec_pkg::axil_req_t  axil_req,
  output ifu_vec_pkg::axil_rsp_t  axil_rsp,
  input  ifu_vec_pkg::vec_state_t cur_state,
  output ifu_vec_pkg::vec_cfg_t   cfg
);

  import ifu_vec_pkg::*;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  logic [RVBR_WIDTH-1:0] rvbr;
  logic [PC_WIDTH-1:0]   eentry;
  logic [2:0]            ecfg_vs;
  logic                  icg_en;
  logic                  wr_rdy;
  logic                  rd_rdy;
  logic                  bvalid;
  logic                  rvalid;
  logic [1:0]            bresp;
  logic [1:0]            rresp;
  logic [31:0]           rdata;
  logic                  wr_fire;
  logic                  rd_fire;
  logic                  wr_err;
  logic                  rd_err;
  logic [31:0]           wr_word;

  // Keep bytes whose strobe is clear
  function automatic logic [31:0] strb_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res;
  endfunction

  // Register contents as seen on the bus
  function automatic logic [31:0] reg_word(input logic [7:0] addr);
    case (addr)
      reg_rvbr_lo   : return rvbr[31:0];
      reg_rvbr_hi   : return {24'b0, rvbr[RVBR_WIDTH-1:32]};
      reg_eentry_lo : return eentry[31:0];
      reg_eentry_hi : return eentry[PC_WIDTH-1:32];
      reg_ecfg      : return {23'b0, icg_en, 5'b0, ecfg_vs};
      // reset_on mirrors the RESET bit of the state word
      reg_status    : return {15'b0, cur_state[8], 6'b0, cur_state};
      default       : return 32'b0;
    endcase
  endfunction

  // ==============================
  // Handshake
  // ==============================
  assign wr_fire = wr_rdy & axil_req.awvalid & axil_req.wvalid;
  assign rd_fire = rd_rdy & axil_req.arvalid;

  // Status is read only, so writes to it fail too
  assign wr_err = !(axil_req.awaddr inside {reg_rvbr_lo, reg_rvbr_hi, reg_eentry_lo,
                                            reg_eentry_hi, reg_ecfg});
  assign rd_err = !(axil_req.araddr inside {reg_rvbr_lo, reg_rvbr_hi, reg_eentry_lo,
                                            reg_eentry_hi, reg_ecfg, reg_status});

  always_ff @(posedge vec_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_rdy <= 1'b0;
      rd_rdy <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      // One-cycle ready pulses, blocked while a response is pending
      wr_rdy <= axil_req.awvalid & axil_req.wvalid & ~wr_rdy & ~bvalid;
      rd_rdy <= axil_req.arvalid & ~rd_rdy & ~rvalid;
      if (wr_fire)
        bvalid <= 1'b1;
      else if (axil_req.bready)
        bvalid <= 1'b0;
      if (rd_fire)
        rvalid <= 1'b1;
      else if (axil_req.rready)
        rvalid <= 1'b0;
    end
  end

  // Response payload
  always_ff @(posedge vec_sm_clk)
  begin
    if (wr_fire)
      bresp <= wr_err ? resp_slverr : resp_okay;
    if (rd_fire)
    begin
      rdata <= reg_word(axil_req.araddr);
      rresp <= rd_err ? resp_slverr : resp_okay;
    end
  end

  // ==============================
  // Register write
  // ==============================
  assign wr_word = strb_merge(reg_word(axil_req.awaddr), axil_req.wdata, axil_req.wstrb);

  always_ff @(posedge vec_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rvbr    <= RVBR_RESET;
      eentry  <= '0;
      ecfg_vs <= 3'b0;
      icg_en  <= 1'b0;
    end
    else if (wr_fire && !wr_err)
    begin
      case (axil_req.awaddr)
        reg_rvbr_lo   : rvbr[31:0]              <= wr_word;
        reg_rvbr_hi   : rvbr[RVBR_WIDTH-1:32]   <= wr_word[7:0];
        reg_eentry_lo : eentry[31:0]            <= wr_word;
        reg_eentry_hi : eentry[PC_WIDTH-1:32]   <= wr_word;
        reg_ecfg      :
        begin
          ecfg_vs <= wr_word[2:0];
          icg_en  <= wr_word[8];
        end
        default       : ;
      endcase
    end
  end

  // Outputs
  assign axil_rsp.awready = wr_rdy;
  assign axil_rsp.wready  = wr_rdy;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = bresp;
  assign axil_rsp.arready = rd_rdy;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = rresp;

  assign cfg.rvbr    = rvbr;
  assign cfg.eentry  = eentry;
  assign cfg.ecfg_vs = ecfg_vs;
  assign cfg.icg_en  = icg_en;

endmodule

`default_nettype wire

// File: hdl/ifu_vec_pkg.sv
/* Fetch vector unit shared definitions: state encoding, sizes,
   register map and the bundles that run between the blocks */
`default_nettype none

package ifu_vec_pkg;

  // ==============================
  // Sizes
  // ==============================
  localparam int PC_WIDTH    = 64;
  localparam int RVBR_WIDTH  = 40;
  localparam int ICACHE_SETS = 64;
  localparam int FETCH_BYTES = 16;

  // Boot address out of reset
  localparam logic [RVBR_WIDTH-1:0] RVBR_RESET = 40'h00_8000_0000;

  // ==============================
  // Vector FSM encoding
  // ==============================
  // One-hot, bits 1 to 7 unused here
  typedef logic [9:0] vec_state_t;

  localparam vec_state_t st_idle   = 10'b00_0000_0001;
  localparam vec_state_t st_reset  = 10'b01_0000_0000;
  localparam vec_state_t st_pcload = 10'b10_0000_0000;

  // ==============================
  // Register map
  // ==============================
  localparam logic [7:0] reg_rvbr_lo   = 8'h00;
  localparam logic [7:0] reg_rvbr_hi   = 8'h04;
  localparam logic [7:0] reg_eentry_lo = 8'h08;
  localparam logic [7:0] reg_eentry_hi = 8'h0C;
  localparam logic [7:0] reg_ecfg      = 8'h10;
  // Read only
  localparam logic [7:0] reg_status    = 8'h14;

  // ==============================
  // Bundles
  // ==============================
  // AXI4-Lite manager side
  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_req_t;

  // AXI4-Lite subordinate side
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic [RVBR_WIDTH-1:0] rvbr;
    logic [PC_WIDTH-1:0]   eentry;
    logic [2:0]            ecfg_vs;
    logic                  icg_en;
  } vec_cfg_t;

  typedef struct packed {
    logic        vld;
    logic [15:0] vec;
  } vec_expt_t;

  // Redirect PC in halfwords
  typedef struct packed {
    logic [PC_WIDTH-2:0] pc;
    logic                pcload;
    logic                reset_on;
  } vec_pcgen_t;

endpackage

`default_nettype wire

// File: hdl/ifu_vec_top.sv
/* Fetch vector top: register block, invalidate walker,
   vector unit and PC generator */
`default_nettype none

module ifu_vec_top (
  input  logic                             vec_sm_clk,
  input  logic                             cpurst_b,
  input  logic                             scan_en,
  input  ifu_vec_pkg::axil_req_t           axil_req,
  output ifu_vec_pkg::axil_rsp_t           axil_rsp,
  input  ifu_vec_pkg::vec_expt_t           expt,
  input  logic                             restart_vld,
  input  logic [ifu_vec_pkg::PC_WIDTH-1:0] restart_entry,
  output logic                             restart_grnt,
  input  logic                             dbg_on,
  input  logic                             fetch_en,
  output logic [ifu_vec_pkg::PC_WIDTH-1:0] fetch_pc,
  output logic                             sync_reset,
  output logic                             sm_on
);

  import ifu_vec_pkg::*;

  vec_cfg_t   cfg;
  vec_state_t cur_state;
  vec_pcgen_t pcgen;
  logic       inv_req;
  logic       inv_done;

  // Config and status
  ifu_vec_csr x_csr (
    .vec_sm_clk (vec_sm_clk),
    .cpurst_b   (cpurst_b),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .cur_state  (cur_state),
    .cfg        (cfg)
  );

  // Reset-time cache invalidate, busy flag not needed here
  ifu_icache_inv x_icache_inv (
    .vec_sm_clk (vec_sm_clk),
    .cpurst_b   (cpurst_b),
    .inv_req    (inv_req),
    .inv_done   (inv_done),
    .inv_busy   ()
  );

  ifu_vector x_vector (
    .vec_sm_clk    (vec_sm_clk),
    .cpurst_b      (cpurst_b),
    .scan_en       (scan_en),
    .cfg           (cfg),
    .expt          (expt),
    .restart_vld   (restart_vld),
    .restart_entry (restart_entry),
    .dbg_on        (dbg_on),
    .inv_done      (inv_done),
    .rst_inv_req   (inv_req),
    .sync_reset    (sync_reset),
    .sm_on         (sm_on),
    .restart_grnt  (restart_grnt),
    .cur_state     (cur_state),
    .pcgen         (pcgen)
  );

  // Byte fetch address
  ifu_pcgen x_pcgen (
    .vec_sm_clk (vec_sm_clk),
    .cpurst_b   (cpurst_b),
    .pcgen      (pcgen),
    .sm_on      (sm_on),
    .fetch_en   (fetch_en),
    .fetch_pc   (fetch_pc)
  );

endmodule

`default_nettype wire

// File: hdl/ifu_vector.sv
/* Fetch vector FSM and redirect PC for reset, exceptions
   and core restart */
`default_nettype none

module ifu_vector (
  input  logic                              vec_sm_clk,
  input  logic                              cpurst_b,
  input  logic                              scan_en,
  input  ifu_vec_pkg::vec_cfg_t             cfg,
  input  ifu_vec_pkg::vec_expt_t            expt,
  input  logic                              restart_vld,
  input  logic [ifu_vec_pkg::PC_WIDTH-1:0]  restart_entry,
  input  logic                              dbg_on,
  input  logic                              inv_done,
  output logic                              rst_inv_req,
  output logic                              sync_reset,
  output logic                              sm_on,
  output logic                              restart_grnt,
  output ifu_vec_pkg::vec_state_t           cur_state,
  output ifu_vec_pkg::vec_pcgen_t           pcgen
);

  import ifu_vec_pkg::*;

  vec_state_t          next_state;
  logic                rst_inv_ff;
  logic                sm_clk;
  logic                sm_clk_en;
  logic                pc_clk;
  logic                pc_clk_en;
  logic                pc_load;
  logic                reset_expt;
  logic [15:0]         expt_off;
  logic [PC_WIDTH-3:0] expt_base;
  logic [PC_WIDTH-2:0] expt_pc;
  logic [PC_WIDTH-2:0] reset_pc;
  logic [PC_WIDTH-2:0] virtual_pc;
  logic [PC_WIDTH-2:0] nonvec_pc;

  // ==============================
  // State machine
  // ==============================
  // Clock only while something is pending or the FSM is busy
  assign sm_clk_en = expt.vld | restart_vld | (cur_state != st_idle);

  gated_clk_cell x_sm_clk (
    .clk_in    (vec_sm_clk),
    .local_en  (sm_clk_en),
    .module_en (cfg.icg_en),
    .scan_en   (scan_en),
    .clk_out   (sm_clk)
  );

  // Reset lands in RESET, debug parks the FSM in IDLE
  always_ff @(posedge sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= st_reset;
    else if (dbg_on)
      cur_state <= st_idle;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    case (cur_state)
      // Restart and exception both take the PCLOAD detour
      st_idle   : next_state = (restart_vld || expt.vld) ? st_pcload : st_idle;
      // Hold until the cache has been invalidated
      st_reset  : next_state = inv_done ? st_idle : st_reset;
      st_pcload : next_state = st_idle;
      default   : next_state = st_idle;
    endcase
  end

  // First RESET cycle marker
  always_ff @(posedge sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rst_inv_ff <= 1'b0;
    else
      rst_inv_ff <= cur_state[8];
  end

  assign rst_inv_req  = cur_state[8] & ~rst_inv_ff;
  assign sync_reset   = cur_state[8];
  assign sm_on        = ~cur_state[0];
  // Restart accepted only in IDLE
  assign restart_grnt = cur_state[0];
  // Reset exit or PCLOAD, never in debug
  assign pc_load      = ~dbg_on & ((cur_state[8] & inv_done) | cur_state[9]);

  // ==============================
  // Redirect PC
  // ==============================
  assign reset_expt = (expt.vec == 16'b0);

  // Vector slot offset in words, 2^vs words per slot
  assign expt_off  = {8'b0, expt.vec[7:0]} << cfg.ecfg_vs;
  assign expt_base = cfg.eentry[PC_WIDTH-1:2];

  // Direct mode ignores the vector number
  assign expt_pc = (cfg.ecfg_vs != 3'b0)
                 ? {expt_base | {{(PC_WIDTH-18){1'b0}}, expt_off}, 1'b0}
                 : {expt_base, 1'b0};

  assign reset_pc = {{(PC_WIDTH-RVBR_WIDTH){1'b0}}, cfg.rvbr[RVBR_WIDTH-1:1]};

  // Reset vector during RESET or for vector zero
  assign virtual_pc = (reset_expt || cur_state[8]) ? reset_pc : expt_pc;

  assign pc_clk_en = expt.vld | restart_vld | cur_state[8];

  gated_clk_cell x_pc_clk (
    .clk_in    (vec_sm_clk),
    .local_en  (pc_clk_en),
    .module_en (cfg.icg_en),
    .scan_en   (scan_en),
    .clk_out   (pc_clk)
  );

  // Restart wins over exceptions
  always_ff @(posedge pc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      nonvec_pc <= '0;
    else if (restart_vld)
      nonvec_pc <= restart_entry[PC_WIDTH-1:1];
    else if (expt.vld || cur_state[8])
      nonvec_pc <= virtual_pc;
  end

  // To PC generator
  assign pcgen.pc       = nonvec_pc;
  assign pcgen.pcload   = pc_load;
  assign pcgen.reset_on = cur_state[8];

endmodule

`default_nettype wire

// File: ifu_vec.f
+incdir+tb
hdl/ifu_vec_pkg.sv
hdl/gated_clk_cell.sv
hdl/ifu_vec_csr.sv
hdl/ifu_icache_inv.sv
hdl/ifu_vector.sv
hdl/ifu_pcgen.sv
hdl/ifu_vec_top.sv
tb/ifu_vec_tb.sv

// File: tb/ifu_vec_tb_ref.svh
/* Reference model: expected redirect address and a shadow
   of the register map as seen over AXI4-Lite */
`ifndef IFU_VEC_TB_REF_SVH
`define IFU_VEC_TB_REF_SVH

// Shadow registers, rvbr lo/hi, eentry lo/hi, ecfg
logic [31:0] shadow [0:4];

// Bits that hold state in each register
function automatic logic [31:0] live_bits(input logic [7:0] addr);
  case (addr)
    reg_rvbr_hi : return 32'h0000_00FF;
    reg_ecfg    : return 32'h0000_0107;
    default     : return 32'hFFFF_FFFF;
  endcase
endfunction

// Strobed write, bytes without a strobe bit keep their value
function automatic void model_write(input logic [7:0] addr, input logic [31:0] data,
                                    input logic [3:0] strb);
  logic [31:0] word;
  word = shadow[addr[4:2]];
  for (int b = 0; b < 4; b++)
  begin
    if (strb[b])
      word[b*8 +: 8] = data[b*8 +: 8];
  end
  shadow[addr[4:2]] = word & live_bits(addr);
endfunction

// Byte address the fetch stage should land on
// Restart first, then vector zero, then direct or vectored
function automatic logic [63:0] expected_redirect(input logic        restart,
                                                  input logic [63:0] rst_entry,
                                                  input logic [15:0] vec,
                                                  input logic [39:0] rvbr,
                                                  input logic [63:0] eentry,
                                                  input logic [2:0]  vs);
  logic [63:0] word_off;
  if (restart)
    return rst_entry & ~64'h1;
  if (vec == 16'h0)
    return {24'b0, rvbr} & ~64'h1;
  if (vs == 3'd0)
    return eentry & ~64'h3;
  // Slot of 2^vs words per vector
  word_off = {56'b0, vec[7:0]} << vs;
  return (eentry & ~64'h3) | (word_off << 2);
endfunction

`endif

// File: tb/ifu_vec_tb.sv
/* Fetch vector unit testbench with clock and reset, AXI4-Lite driver,
   redirect stimulus and the comparing process */
`default_nettype none

module ifu_vec_tb;

  import ifu_vec_pkg::*;

  localparam int         wait_limit  = 200;
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  logic                vec_sm_clk;
  logic                cpurst_b;
  logic                scan_en;
  axil_req_t           axil_req;
  axil_rsp_t           axil_rsp;
  vec_expt_t           expt;
  logic                restart_vld;
  logic [PC_WIDTH-1:0] restart_entry;
  logic                restart_grnt;
  logic                dbg_on;
  logic                fetch_en;
  logic [PC_WIDTH-1:0] fetch_pc;
  logic                sync_reset;
  logic                sm_on;

  int                  seed      = 62;
  logic                cmp_armed = 1'b0;
  logic [PC_WIDTH-1:0] exp_pc;

  `include "ifu_vec_tb_ref.svh"

  ifu_vec_top ifu_vec_top_inst (
    .vec_sm_clk    (vec_sm_clk),
    .cpurst_b      (cpurst_b),
    .scan_en       (scan_en),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .expt          (expt),
    .restart_vld   (restart_vld),
    .restart_entry (restart_entry),
    .restart_grnt  (restart_grnt),
    .dbg_on        (dbg_on),
    .fetch_en      (fetch_en),
    .fetch_pc      (fetch_pc),
    .sync_reset    (sync_reset),
    .sm_on         (sm_on)
  );

  // ==============================
  // Clock
  // ==============================
  initial
  begin
    vec_sm_clk = 1'b0;
    forever
    begin
      #2 vec_sm_clk = ~vec_sm_clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  // ==============================
  // AXI4-Lite driver
  // ==============================
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] bresp);
    int t;
    @(posedge vec_sm_clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    axil_req.bready  <= 1'b1;
    // Address and data go in together
    t = 0;
    @(negedge vec_sm_clk);
    while (!axil_rsp.awready)
    begin
      if (t == wait_limit)
        abort_run("AXI write was never accepted");
      t++;
      @(negedge vec_sm_clk);
    end
    @(posedge vec_sm_clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    t = 0;
    @(negedge vec_sm_clk);
    while (!axil_rsp.bvalid)
    begin
      if (t == wait_limit)
        abort_run("AXI write response never came");
      t++;
      @(negedge vec_sm_clk);
    end
    bresp = axil_rsp.bresp;
    @(posedge vec_sm_clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] rresp);
    int t;
    @(posedge vec_sm_clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.rready  <= 1'b1;
    t = 0;
    @(negedge vec_sm_clk);
    while (!axil_rsp.arready)
    begin
      if (t == wait_limit)
        abort_run("AXI read address was never accepted");
      t++;
      @(negedge vec_sm_clk);
    end
    @(posedge vec_sm_clk);
    axil_req.arvalid <= 1'b0;
    t = 0;
    @(negedge vec_sm_clk);
    while (!axil_rsp.rvalid)
    begin
      if (t == wait_limit)
        abort_run("AXI read data never came");
      t++;
      @(negedge vec_sm_clk);
    end
    data  = axil_rsp.rdata;
    rresp = axil_rsp.rresp;
    @(posedge vec_sm_clk);
    axil_req.rready <= 1'b0;
  endtask

  // Mapped write with the shadow following
  task automatic set_reg(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
    logic [1:0] resp;
    write_reg(addr, data, strb, resp);
    compare_val("bresp", 64'(resp), 64'(resp_okay));
    model_write(addr, data, strb);
  endtask

  // Read back against the shadow
  task automatic verify_reg(input logic [7:0] addr);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(addr, data, resp);
    compare_val("rresp", 64'(resp), 64'(resp_okay));
    compare_val($sformatf("rdata@%h", addr), 64'(data), 64'(shadow[addr[4:2]]));
  endtask

  // ==============================
  // Redirect stimulus
  // ==============================
  task automatic redirect_and_wait(input logic is_restart, input logic [15:0] v,
                                   input logic [63:0] rentry);
    int t;
    exp_pc = expected_redirect(is_restart, rentry, v, {shadow[1][7:0], shadow[0]},
                               {shadow[3], shadow[2]}, shadow[4][2:0]);
    cmp_armed = 1'b1;
    @(posedge vec_sm_clk);
    if (is_restart)
    begin
      restart_vld   <= 1'b1;
      restart_entry <= rentry;
    end
    else
    begin
      expt.vld <= 1'b1;
      expt.vec <= v;
    end
    // One-cycle request
    @(posedge vec_sm_clk);
    restart_vld <= 1'b0;
    expt.vld    <= 1'b0;
    t = 0;
    while (cmp_armed)
    begin
      if (t == wait_limit)
        abort_run("Redirect never reached the fetch PC");
      t++;
      @(negedge vec_sm_clk);
    end
  endtask

  // Grant drop marks PCLOAD and fetch_pc settles one cycle later
  always @(negedge vec_sm_clk)
  begin
    if (cmp_armed && !restart_grnt)
    begin
      compare_val("sm_on", 64'(sm_on), 64'd1);
      @(negedge vec_sm_clk);
      compare_val("restart_grnt", 64'(restart_grnt), 64'd1);
      compare_val("sm_on", 64'(sm_on), 64'd0);
      compare_val("fetch_pc", fetch_pc, exp_pc);
      cmp_armed = 1'b0;
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial
  begin
    int          t;
    logic [31:0] data;
    logic [1:0]  resp;
    logic [15:0] vec;
    logic [2:0]  vs;
    logic [63:0] entry;
    logic [63:0] hold_pc;
    cpurst_b      = 1'b0;
    scan_en       = 1'b0;
    axil_req      = '0;
    expt          = '0;
    restart_vld   = 1'b0;
    restart_entry = '0;
    dbg_on        = 1'b0;
    fetch_en      = 1'b0;
    shadow[0]     = RVBR_RESET[31:0];
    shadow[1]     = {24'b0, RVBR_RESET[39:32]};
    shadow[2]     = 32'h0;
    shadow[3]     = 32'h0;
    shadow[4]     = 32'h0;
    repeat (8) @(posedge vec_sm_clk);
    cpurst_b <= 1'b1;

    // Reset state and then the invalidate walk
    @(negedge vec_sm_clk);
    compare_val("sync_reset", 64'(sync_reset), 64'd1);
    compare_val("sm_on", 64'(sm_on), 64'd1);
    compare_val("restart_grnt", 64'(restart_grnt), 64'd0);
    compare_val("bvalid", 64'(axil_rsp.bvalid), 64'd0);
    compare_val("rvalid", 64'(axil_rsp.rvalid), 64'd0);
    t = 0;
    while (sync_reset)
    begin
      if (t == wait_limit)
        abort_run("sync_reset never released");
      t++;
      @(negedge vec_sm_clk);
    end
    compare_val("sm_on", 64'(sm_on), 64'd0);
    compare_val("fetch_pc", fetch_pc, expected_redirect(1'b0, 64'h0, 16'h0,
                {shadow[1][7:0], shadow[0]}, 64'h0, 3'd0));

    // Partial strobes
    set_reg(reg_rvbr_lo, 32'h1234_5678, 4'b0101);
    set_reg(reg_rvbr_hi, 32'hFFFF_FF5A, 4'b0001);
    set_reg(reg_eentry_lo, 32'($random(seed)), 4'b1100);
    set_reg(reg_eentry_hi, 32'($random(seed)), 4'b0011);
    set_reg(reg_ecfg, 32'h0000_0105, 4'b0010);
    set_reg(reg_ecfg, 32'h0000_0006, 4'b0001);
    for (int a = 0; a < 5; a++)
    begin
      verify_reg(8'(a * 4));
    end
    read_reg(8'h20, data, resp);
    compare_val("rresp unmapped", 64'(resp), 64'(resp_slverr));
    write_reg(reg_status, 32'hFFFF_FFFF, 4'b1111, resp);
    compare_val("bresp status", 64'(resp), 64'(resp_slverr));
    read_reg(reg_status, data, resp);
    compare_val("rresp status", 64'(resp), 64'(resp_okay));
    compare_val("status", 64'(data), 64'(st_idle));

    // Direct and vectored exceptions with the first one direct
    for (int n = 0; n < 12; n++)
    begin
      entry = {32'($random(seed)), 32'($random(seed))};
      vs    = (n == 0) ? 3'd0 : 3'($random(seed));
      vec   = 16'($random(seed));
      if (vec == 16'h0)
        vec = 16'h1;
      set_reg(reg_eentry_lo, entry[31:0], 4'b1111);
      set_reg(reg_eentry_hi, entry[63:32], 4'b1111);
      set_reg(reg_ecfg, {23'b0, 1'($random(seed)), 5'b0, vs}, 4'b1111);
      redirect_and_wait(1'b0, vec, 64'h0);
    end

    // Vector zero picks up a new reset base
    set_reg(reg_rvbr_lo, 32'($random(seed)), 4'b1111);
    set_reg(reg_rvbr_hi, 32'($random(seed)), 4'b1111);
    redirect_and_wait(1'b0, 16'h0, 64'h0);

    // Core restart
    for (int n = 0; n < 4; n++)
    begin
      entry = {32'($random(seed)), 32'($random(seed))};
      redirect_and_wait(1'b1, 16'h0, entry);
    end

    // Debug blocks the redirect
    @(negedge vec_sm_clk);
    hold_pc = fetch_pc;
    @(posedge vec_sm_clk);
    dbg_on <= 1'b1;
    @(posedge vec_sm_clk);
    expt.vld <= 1'b1;
    expt.vec <= 16'($random(seed)) | 16'h1;
    @(posedge vec_sm_clk);
    expt.vld <= 1'b0;
    repeat (3) @(posedge vec_sm_clk);
    @(negedge vec_sm_clk);
    compare_val("fetch_pc dbg", fetch_pc, hold_pc);

    // Sequential fetch of one block per cycle
    @(posedge vec_sm_clk);
    fetch_en <= 1'b1;
    for (int n = 0; n < 5; n++)
    begin
      @(posedge vec_sm_clk);
      @(negedge vec_sm_clk);
      hold_pc = (hold_pc + 64'(FETCH_BYTES)) & ~64'(FETCH_BYTES - 1);
      compare_val("fetch_pc seq", fetch_pc, hold_pc);
    end
    @(posedge vec_sm_clk);
    fetch_en <= 1'b0;
    dbg_on   <= 1'b0;
    repeat (2) @(posedge vec_sm_clk);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
